/* bus_pkg.sv */
/*
  processor bus types, request struct and the address map
  of the decoded RAM and timer regions
*/
package bus_pkg;

  // ------------------------------------------------
  // data and address
  // ------------------------------------------------

  typedef logic [31:0] word_t;   // bus data word
  typedef logic [31:2] waddr_t;  // word address, byte bits 31..2

  // request from the bus master, held stable until ack
  typedef struct packed {
    logic   stb;                 // bus strobe
    logic   we;                  // write enable
    waddr_t addr;                // word address
    word_t  wdata;               // write data
  } bus_req_t;

  // interrupt vector
  localparam int IRQ_W    = 16;
  localparam int IRQ_TMR0 = 14;  // timer 0 line
  localparam int IRQ_TMR1 = 15;  // timer 1 line

  // ------------------------------------------------
  // address map
  // ------------------------------------------------

  // RAM window, 128 MB of a 512 MB architectural region
  localparam logic [2:0] RAM_TOP = 3'b000;  // addr[31:29]
  localparam logic [1:0] RAM_LIM = 2'b00;   // addr[28:27]

  // I/O region and the timer page within it
  localparam logic [3:0] IO_SEL   = 4'h3;   // addr[31:28]
  localparam logic [7:0] TMR_PAGE = 8'h00;  // addr[27:20]
  localparam logic [7:0] TMR0_SEL = 8'h00;  // addr[19:12]
  localparam logic [7:0] TMR1_SEL = 8'h01;

endpackage

/* dev_pkg.sv */
/*
  device constants: RAM size and wait states,
  timer register indexes and control bits
*/
package dev_pkg;

  // ------------------------------------------------
  // RAM
  // ------------------------------------------------

  localparam int RAM_AW    = 10;                   // 1024 words
  localparam int RAM_WAIT  = 2;                    // wait cycles per access
  localparam int RAM_CNT_W = $clog2(RAM_WAIT + 1); // wait counter width

  // ------------------------------------------------
  // timer registers
  // ------------------------------------------------

  localparam logic [1:0] TMR_REG_CTRL = 2'd0;  // control / status
  localparam logic [1:0] TMR_REG_DIV  = 2'd1;  // divisor
  localparam logic [1:0] TMR_REG_CNT  = 2'd2;  // counter, read only

  // control register bits
  localparam int TMR_CTRL_EXP = 0;  // expired flag
  localparam int TMR_CTRL_IEN = 1;  // interrupt enable

endpackage

/* ram_array.sv */
/*
  synchronous single-port word memory, read port
  registered on enable
*/
`timescale 1ns/1ps

module ram_array (
  input  logic                     clk,
  input  logic                     i_en,
  input  logic                     i_we,
  input  logic [dev_pkg::RAM_AW-1:0] i_addr,
  input  bus_pkg::word_t           i_wdata,
  output bus_pkg::word_t           o_rdata
);

  import bus_pkg::*;
  import dev_pkg::*;

  word_t mem [2**RAM_AW];

  always_ff @(posedge clk) begin
    if (i_en) begin
      if (i_we) mem[i_addr] <= i_wdata;
      else o_rdata <= mem[i_addr];  // holds until next read
    end
  end

endmodule

/* ram_ctrl.sv */
/*
  RAM controller: sequences one access through fixed
  wait states and acknowledges it for a single cycle
*/
`timescale 1ns/1ps

module ram_ctrl (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_stb,
  input  logic            i_we,
  input  bus_pkg::waddr_t i_addr,
  input  bus_pkg::word_t  i_wdata,
  output bus_pkg::word_t  o_rdata,
  output logic            o_ack
);

  import dev_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DONE
  } state_t;

  state_t               state;
  logic [RAM_CNT_W-1:0] wait_cnt;  // counts down to zero in WAIT
  logic                 ram_en;

  // ------------------------------------------------
  // access FSM
  // ------------------------------------------------

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (i_stb) begin
            state    <= WAIT;
            wait_cnt <= RAM_CNT_W'(RAM_WAIT);
          end
        end
        WAIT: begin
          if (wait_cnt == '0) state <= DONE;  // array access this edge
          else wait_cnt <= wait_cnt - 1'b1;
        end
        default: state <= IDLE;  // DONE, strobe still high is ignored
      endcase
    end
  end

  // one enable pulse, so read data registers just as DONE starts
  assign ram_en = (state == WAIT) && (wait_cnt == '0);
  assign o_ack  = (state == DONE);

  ram_array i_ram_array (
    .clk     (clk),
    .i_en    (ram_en),
    .i_we    (i_we),
    .i_addr  (i_addr[RAM_AW+1:2]),  // aliases inside the RAM window
    .i_wdata (i_wdata),
    .o_rdata (o_rdata)
  );

endmodule

/* addr_decoder.sv */
/*
  bus address decoder: device strobes, read data and
  acknowledge multiplexers, interrupt vector
*/
`timescale 1ns/1ps

module addr_decoder (
  input  bus_pkg::bus_req_t          i_bus,
  output logic                       o_ram_stb,
  output logic                       o_tmr_0_stb,
  output logic                       o_tmr_1_stb,
  input  bus_pkg::word_t             i_ram_rdata,
  input  bus_pkg::word_t             i_tmr_0_rdata,
  input  bus_pkg::word_t             i_tmr_1_rdata,
  input  logic                       i_ram_ack,
  input  logic                       i_tmr_0_ack,
  input  logic                       i_tmr_1_ack,
  input  logic                       i_tmr_0_irq,
  input  logic                       i_tmr_1_irq,
  output bus_pkg::word_t             o_rdata,
  output logic                       o_ack,
  output logic [bus_pkg::IRQ_W-1:0]  o_irq
);

  import bus_pkg::*;

  logic io_stb;  // anywhere in the I/O region

  // ------------------------------------------------
  // region decode
  // ------------------------------------------------

  assign o_ram_stb = i_bus.stb && i_bus.addr[31:29] == RAM_TOP
                               && i_bus.addr[28:27] == RAM_LIM;

  assign io_stb = i_bus.stb && i_bus.addr[31:28] == IO_SEL;

  assign o_tmr_0_stb = io_stb && i_bus.addr[27:20] == TMR_PAGE
                              && i_bus.addr[19:12] == TMR0_SEL;
  assign o_tmr_1_stb = io_stb && i_bus.addr[27:20] == TMR_PAGE
                              && i_bus.addr[19:12] == TMR1_SEL;

  // ------------------------------------------------
  // read data and ack back to the master
  // ------------------------------------------------

  always_comb begin
    o_rdata = '0;  // unmapped reads as zero, no ack
    o_ack   = 1'b0;
    if (o_ram_stb) begin
      o_rdata = i_ram_rdata;
      o_ack   = i_ram_ack;
    end else if (o_tmr_0_stb) begin
      o_rdata = i_tmr_0_rdata;
      o_ack   = i_tmr_0_ack;
    end else if (o_tmr_1_stb) begin
      o_rdata = i_tmr_1_rdata;
      o_ack   = i_tmr_1_ack;
    end
  end

  // only the two timer lines are in use
  always_comb begin
    o_irq           = '0;
    o_irq[IRQ_TMR0] = i_tmr_0_irq;
    o_irq[IRQ_TMR1] = i_tmr_1_irq;
  end

endmodule

/* tmr.sv */
/*
  interval timer: divisor, down-counter, expired flag
  and interrupt enable behind three bus registers
*/
`timescale 1ns/1ps

module tmr (
  input  logic           clk,
  input  logic           i_rst_n,
  input  logic           i_stb,
  input  logic           i_we,
  input  logic [1:0]     i_reg,
  input  bus_pkg::word_t i_wdata,
  output bus_pkg::word_t o_rdata,
  output logic           o_ack,
  output logic           o_irq
);

  import bus_pkg::*;
  import dev_pkg::*;

  word_t divisor;
  word_t counter;
  logic  expired;
  logic  irq_en;
  logic  wr_ctrl;
  logic  wr_div;

  assign wr_ctrl = i_stb && i_we && i_reg == TMR_REG_CTRL;
  assign wr_div  = i_stb && i_we && i_reg == TMR_REG_DIV;

  // ------------------------------------------------
  // counter and control state
  // ------------------------------------------------

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      divisor <= '1;
      counter <= '1;
      expired <= 1'b0;
      irq_en  <= 1'b0;
    end else begin
      if (wr_div) begin
        divisor <= i_wdata;
        counter <= i_wdata;  // restart the interval
      end else if (counter == 32'd1) begin
        counter <= divisor;
      end else begin
        counter <= counter - 1'b1;
      end

      // a control write overrides an expiry in the same cycle
      if (wr_ctrl) begin
        expired <= i_wdata[TMR_CTRL_EXP];
        irq_en  <= i_wdata[TMR_CTRL_IEN];
      end else if (!wr_div && counter == 32'd1) begin
        expired <= 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // register read, no wait states
  // ------------------------------------------------

  always_comb begin
    o_rdata = '0;
    case (i_reg)
      TMR_REG_CTRL: begin
        o_rdata[TMR_CTRL_EXP] = expired;
        o_rdata[TMR_CTRL_IEN] = irq_en;
      end
      TMR_REG_DIV: o_rdata = divisor;
      TMR_REG_CNT: o_rdata = counter;
      default:     o_rdata = '0;  // unused index
    endcase
  end

  assign o_ack = i_stb;
  assign o_irq = expired & irq_en;

endmodule

/* eco32_io.sv */
/*
  bus side top level: address decoder, RAM path
  and two interval timers
*/
`timescale 1ns/1ps

module eco32_io (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  bus_pkg::bus_req_t         i_bus,
  output bus_pkg::word_t            o_rdata,
  output logic                      o_ack,
  output logic [bus_pkg::IRQ_W-1:0] o_irq
);

  import bus_pkg::*;

  // ram
  logic  ram_stb;
  word_t ram_rdata;
  logic  ram_ack;
  // tmr 0
  logic  tmr_0_stb;
  word_t tmr_0_rdata;
  logic  tmr_0_ack;
  logic  tmr_0_irq;
  // tmr 1
  logic  tmr_1_stb;
  word_t tmr_1_rdata;
  logic  tmr_1_ack;
  logic  tmr_1_irq;

  // ------------------------------------------------
  // instances
  // ------------------------------------------------

  addr_decoder i_addr_decoder (
    .i_bus         (i_bus),
    .o_ram_stb     (ram_stb),
    .o_tmr_0_stb   (tmr_0_stb),
    .o_tmr_1_stb   (tmr_1_stb),
    .i_ram_rdata   (ram_rdata),
    .i_tmr_0_rdata (tmr_0_rdata),
    .i_tmr_1_rdata (tmr_1_rdata),
    .i_ram_ack     (ram_ack),
    .i_tmr_0_ack   (tmr_0_ack),
    .i_tmr_1_ack   (tmr_1_ack),
    .i_tmr_0_irq   (tmr_0_irq),
    .i_tmr_1_irq   (tmr_1_irq),
    .o_rdata       (o_rdata),
    .o_ack         (o_ack),
    .o_irq         (o_irq)
  );

  ram_ctrl i_ram_ctrl (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_stb   (ram_stb),
    .i_we    (i_bus.we),
    .i_addr  (i_bus.addr),
    .i_wdata (i_bus.wdata),
    .o_rdata (ram_rdata),
    .o_ack   (ram_ack)
  );

  tmr i_tmr_0 (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_stb   (tmr_0_stb),
    .i_we    (i_bus.we),
    .i_reg   (i_bus.addr[3:2]),
    .i_wdata (i_bus.wdata),
    .o_rdata (tmr_0_rdata),
    .o_ack   (tmr_0_ack),
    .o_irq   (tmr_0_irq)
  );

  tmr i_tmr_1 (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_stb   (tmr_1_stb),
    .i_we    (i_bus.we),
    .i_reg   (i_bus.addr[3:2]),
    .i_wdata (i_bus.wdata),
    .o_rdata (tmr_1_rdata),
    .o_ack   (tmr_1_ack),
    .o_irq   (tmr_1_irq)
  );

endmodule

/* eco32_io_checker.sv */
/*
  bus protocol assertions, bound into the top level
*/
`timescale 1ns/1ps

module eco32_io_checker (
  input logic                      clk,
  input logic                      i_rst_n,
  input logic                      i_stb,
  input logic                      i_ack,
  input logic                      i_ram_stb,
  input logic                      i_tmr_0_stb,
  input logic                      i_tmr_1_stb,
  input logic                      i_ram_ack,
  input logic [bus_pkg::IRQ_W-1:0] i_irq
);

  import bus_pkg::*;

  // ------------------------------------------------
  // protocol rules
  // ------------------------------------------------

  a_ack_needs_stb: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_ack |-> i_stb) else $error("acknowledge without bus strobe");

  a_one_dev_stb: assert property (@(posedge clk) disable iff (!i_rst_n)
    $onehot0({i_ram_stb, i_tmr_0_stb, i_tmr_1_stb})) else $error("several device strobes");

  // only the timer lines may be raised
  a_irq_unused: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_irq & ~((IRQ_W'(1) << IRQ_TMR0) | (IRQ_W'(1) << IRQ_TMR1))) == '0)
    else $error("unused interrupt line raised");

  a_ram_ack_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_ram_ack |=> !i_ram_ack) else $error("RAM ack longer than one cycle");

endmodule

bind eco32_io eco32_io_checker i_checker (
  .clk         (clk),
  .i_rst_n     (i_rst_n),
  .i_stb       (i_bus.stb),
  .i_ack       (o_ack),
  .i_ram_stb   (ram_stb),
  .i_tmr_0_stb (tmr_0_stb),
  .i_tmr_1_stb (tmr_1_stb),
  .i_ram_ack   (ram_ack),
  .i_irq       (o_irq)
);

/* tb_clk_gen.sv */
/*
  testbench clock and power-on reset
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_NS    = 20;  // 40 ns period
  localparam int RST_CYCLES = 3;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #2 o_rst_n = 1'b1;  // released clear of the edge
  end

endmodule

/* tb_eco32_io.sv */
/*
  testbench for the bus side top level: bus master tasks,
  reference model of RAM and timers, compare process
*/
`timescale 1ns/1ps

module tb_eco32_io;

  import bus_pkg::*;
  import dev_pkg::*;

  localparam int          DRV_DLY   = 2;   // ns after the rising edge
  localparam int          ACK_LIMIT = 16;  // cycles per bus access
  localparam logic [31:0] SEED      = 32'h38d7_584e;
  localparam logic [31:0] POLY      = 32'hd000_0001;

  logic             clk;
  logic             rst_n;
  bus_req_t         bus_req;
  word_t            rdata;
  logic             ack;
  logic [IRQ_W-1:0] irq;

  logic [31:0] lfsr;
  int unsigned cyc;      // rising edges since reset release
  int unsigned ack_cyc;  // cycle of the last ack
  bit          irq_on;

  // reference model state
  word_t  ram_model [int];
  longint tmr_div [2];
  longint tmr_load [2];      // edge of the last divisor load
  longint tmr_ctrl_cyc [2];  // expiries after this edge count
  bit     exp_base [2];
  bit     ien [2];

  // pending compares
  string       cmp_name [$];
  logic [31:0] cmp_got [$];
  logic [31:0] cmp_exp [$];

  tb_clk_gen i_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

  eco32_io i_dut (
    .clk     (clk),
    .i_rst_n (rst_n),
    .i_bus   (bus_req),
    .o_rdata (rdata),
    .o_ack   (ack),
    .o_irq   (irq)
  );

  always @(posedge clk) if (rst_n) cyc <= cyc + 1;

  // ------------------------------------------------
  // reporting and compare
  // ------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp));
  endtask

  function automatic void push_cmp(string name, logic [31:0] got, logic [31:0] exp);
    cmp_name.push_back(name);
    cmp_got.push_back(got);
    cmp_exp.push_back(exp);
  endfunction

  // samples queued off the rising edge and compared on it
  always @(posedge clk) begin
    while (cmp_got.size() > 0)
      check(cmp_name.pop_front(), cmp_got.pop_front(), cmp_exp.pop_front());
  end

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ POLY : lfsr >> 1;
    end
    return v;
  endfunction

  // ------------------------------------------------
  // reference model
  // ------------------------------------------------

  function automatic bit is_ram(logic [31:0] a);
    return a[31:29] == RAM_TOP && a[28:27] == RAM_LIM;
  endfunction

  function automatic int tmr_index(logic [31:0] a);
    if (a[31:28] != IO_SEL || a[27:20] != TMR_PAGE) return -1;
    if (a[19:12] == TMR0_SEL) return 0;
    if (a[19:12] == TMR1_SEL) return 1;
    return -1;
  endfunction

  function automatic logic [31:0] tmr_addr(int t, logic [1:0] r);
    return {IO_SEL, TMR_PAGE, (t == 1) ? TMR1_SEL : TMR0_SEL, 8'h00, r, 2'b00};
  endfunction

  function automatic logic [31:0] ram_rand_addr();
    logic [14:0] hi;
    logic [3:0]  lo;
    hi = rand_bits(15);
    lo = rand_bits(4);
    return {5'b0, hi, 6'b0, lo, 2'b00};  // 16 aliased words
  endfunction

  // first expiry edge after the last control write
  function automatic bit exp_at(int t, longint now);
    longint k;
    if (exp_base[t]) return 1'b1;
    if (tmr_ctrl_cyc[t] >= tmr_load[t]) k = (tmr_ctrl_cyc[t] - tmr_load[t]) / tmr_div[t] + 1;
    else k = 1;
    return tmr_load[t] + k * tmr_div[t] <= now;
  endfunction

  function automatic logic [IRQ_W-1:0] ref_irq(longint now);
    logic [IRQ_W-1:0] v;
    v           = '0;
    v[IRQ_TMR0] = exp_at(0, now) & ien[0];
    v[IRQ_TMR1] = exp_at(1, now) & ien[1];
    return v;
  endfunction

  function automatic word_t ref_read(logic [31:0] a, longint now);
    word_t v;
    int    t;
    v = '0;
    t = tmr_index(a);
    if (is_ram(a)) v = ram_model[int'(a[RAM_AW+1:2])];
    else if (t >= 0) begin
      case (a[3:2])
        TMR_REG_CTRL: begin
          v[TMR_CTRL_EXP] = exp_at(t, now);
          v[TMR_CTRL_IEN] = ien[t];
        end
        TMR_REG_DIV: v = word_t'(tmr_div[t]);
        TMR_REG_CNT: v = word_t'(tmr_div[t] - (now - tmr_load[t]) % tmr_div[t]);
        default:     v = '0;
      endcase
    end
    return v;
  endfunction

  // w is the edge at which the write lands
  function automatic void model_write(logic [31:0] a, word_t d, longint w);
    int t;
    t = tmr_index(a);
    if (is_ram(a)) ram_model[int'(a[RAM_AW+1:2])] = d;
    else if (t >= 0 && a[3:2] == TMR_REG_CTRL) begin
      exp_base[t]     = d[TMR_CTRL_EXP];
      ien[t]          = d[TMR_CTRL_IEN];
      tmr_ctrl_cyc[t] = w;
    end else if (t >= 0 && a[3:2] == TMR_REG_DIV) begin
      exp_base[t]     = exp_at(t, w - 1);  // expiry at w itself is lost
      tmr_ctrl_cyc[t] = w - 1;
      tmr_div[t]      = d;
      tmr_load[t]     = w;
    end
  endfunction

  // ------------------------------------------------
  // bus master
  // ------------------------------------------------

  task automatic bus_xfer(input logic we, input logic [31:0] a, input word_t wd,
                          output word_t rd, output int lat, output bit acked);
    @(posedge clk);
    #DRV_DLY;
    bus_req.stb   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = a[31:2];
    bus_req.wdata = wd;
    lat   = 0;
    acked = 1'b0;
    rd    = '0;
    while (!acked && lat < ACK_LIMIT) begin
      @(negedge clk);
      if (ack) begin
        acked   = 1'b1;
        rd      = rdata;
        ack_cyc = cyc;
      end else lat++;
    end
    @(posedge clk);  // ack taken on this edge
    #DRV_DLY;
    bus_req = '0;
  endtask

  function automatic void check_ack_edges(logic [31:0] a, int lat);
    if (is_ram(a)) push_cmp("o_ack edges", lat - 1, RAM_WAIT + 1);  // after sampling edge
    else push_cmp("o_ack edges", lat, 0);
  endfunction

  task automatic bus_write(input logic [31:0] a, input word_t d);
    word_t rd;
    int    lat;
    bit    ok;
    bus_xfer(1'b1, a, d, rd, lat, ok);
    if (!ok) abort_run("no acknowledge from bus");
    model_write(a, d, ack_cyc + 1);
    check_ack_edges(a, lat);
  endtask

  task automatic bus_read(input logic [31:0] a);
    word_t rd;
    int    lat;
    bit    ok;
    bus_xfer(1'b0, a, '0, rd, lat, ok);
    if (!ok) abort_run("no acknowledge from bus");
    push_cmp("o_rdata", rd, ref_read(a, ack_cyc));
    check_ack_edges(a, lat);
  endtask

  task automatic wait_until_cyc(input longint target);
    int n;
    n = 0;
    while (cyc < target) begin
      @(negedge clk);
      n++;
      if (n > 256) abort_run("timer expiry wait ran too long");
    end
  endtask

  // ------------------------------------------------
  // tests
  // ------------------------------------------------

  task automatic ram_write_read();
    logic [31:0] addrs [$];
    logic [31:0] a;
    logic [31:0] tmp;
    logic [14:0] hi;
    int          j;
    for (int i = 0; i < 24; i++) begin
      a = ram_rand_addr();
      bus_write(a, rand_bits(32));
      addrs.push_back(a);
    end
    for (int i = addrs.size() - 1; i > 0; i--) begin  // shuffle
      j        = int'(rand_bits(5)) % (i + 1);
      tmp      = addrs[i];
      addrs[i] = addrs[j];
      addrs[j] = tmp;
    end
    foreach (addrs[i]) begin
      hi = rand_bits(15);
      bus_read({5'b0, hi, addrs[i][11:0]});  // other alias
    end
  endtask

  task automatic unmapped_access();
    word_t       rd;
    int          lat;
    bit          ok;
    logic [31:0] a;
    bus_xfer(1'b0, 32'h2000_0040, '0, rd, lat, ok);
    push_cmp("o_ack", 32'(ok), 32'd0);
    bus_xfer(1'b1, 32'h3000_2008, 32'h1234_5678, rd, lat, ok);  // no timer 2
    push_cmp("o_ack", 32'(ok), 32'd0);
    a = ram_rand_addr();
    bus_write(a, rand_bits(32));
    bus_read(a);
  endtask

  task automatic timer_irq_raise(input int t);
    int          line;
    int          n;
    longint      w;
    logic [31:0] d;
    line = (t == 1) ? IRQ_TMR1 : IRQ_TMR0;
    d    = 3 + rand_bits(4);
    bus_write(tmr_addr(1 - t, TMR_REG_CTRL), '0);  // other line held low
    bus_write(tmr_addr(t, TMR_REG_CTRL), 32'd1 << TMR_CTRL_IEN);
    bus_write(tmr_addr(t, TMR_REG_DIV), d);
    w = ack_cyc + 1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!irq[line] && n < 64);
    if (!irq[line]) abort_run("timer interrupt never raised");
    push_cmp("o_irq edge", cyc, 32'(w + d));
  endtask

  task automatic timer_irq_clear();
    logic [31:0] d;
    bus_write(tmr_addr(0, TMR_REG_CTRL), '0);  // irq checks run every cycle
    bus_write(tmr_addr(1, TMR_REG_CTRL), '0);
    d = 3 + rand_bits(3);
    bus_write(tmr_addr(1, TMR_REG_DIV), d);
    wait_until_cyc(ack_cyc + 1 + d);
    bus_read(tmr_addr(1, TMR_REG_CTRL));  // expired, still no irq
    bus_read(tmr_addr(0, TMR_REG_CTRL));
  endtask

  task automatic mixed_traffic();
    logic [31:0] a;
    repeat (6) begin
      a = ram_rand_addr();
      bus_write(a, rand_bits(32));
      bus_read(tmr_addr(0, TMR_REG_CNT));
      bus_read(a);
      bus_write(tmr_addr(1, TMR_REG_DIV), 4 + rand_bits(4));
      bus_read(tmr_addr(1, TMR_REG_CNT));
      bus_read(tmr_addr(0, 2'd3));  // unused index
    end
  endtask

  initial begin
    int n;
    bus_req = '0;
    lfsr    = SEED;
    irq_on  = 1'b0;
    for (int t = 0; t < 2; t++) begin
      tmr_div[t]      = 64'hffff_ffff;  // counter runs down from all-ones
      tmr_load[t]     = 0;
      tmr_ctrl_cyc[t] = 0;
      exp_base[t]     = 1'b0;
      ien[t]          = 1'b0;
    end
    n = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > 8) abort_run("reset was never released");
    end
    #DRV_DLY;
    irq_on = 1'b1;

    for (int t = 0; t < 2; t++) begin
      for (int r = 0; r < 3; r++) bus_read(tmr_addr(t, 2'(r)));
    end
    ram_write_read();
    unmapped_access();
    timer_irq_raise(0);
    timer_irq_raise(1);
    timer_irq_clear();
    mixed_traffic();

    irq_on = 1'b0;
    n      = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cmp_got.size() > 0 && n < 4);
    if (cmp_got.size() > 0) abort_run("compare queue did not drain");
    else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  always @(negedge clk) if (irq_on) push_cmp("o_irq", 32'(irq), 32'(ref_irq(cyc)));

endmodule

/* flist.f */
bus_pkg.sv
dev_pkg.sv
ram_array.sv
ram_ctrl.sv
addr_decoder.sv
tmr.sv
eco32_io.sv
eco32_io_checker.sv
tb_clk_gen.sv
tb_eco32_io.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the eco32_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_eco32_io \
  --Mdir obj_dir -o sim_eco32_io \
  -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_eco32_io
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0
